// ==== logic/haar_consts.svh ====
`ifndef HAAR_CONSTS_SVH
`define HAAR_CONSTS_SVH

// Window geometry
`define HAAR_WIN_W 10
`define HAAR_WIN_H 10
`define HAAR_WIN_SIZE 100

// Corner index into the window store
`define HAAR_IDX_W 7

// Database and integral word width
`define HAAR_VAL_W 16

// Signed feature and stage sums
`define HAAR_ACC_W 32

`define HAAR_DB_AW 12
`define HAAR_FEAT_WORDS 18

`endif

// ==== logic/haar_pkg.sv ====
`default_nettype none

`include "haar_consts.svh"

package haar_pkg;

	// First word of every stage
	typedef struct packed {
		logic       last;
		logic [6:0] rsvd;
		logic [7:0] feat_count;
	} stage_hdr_t;

	// One ROM word read as a header or as a plain value
	typedef union packed {
		stage_hdr_t                    hdr;
		logic signed [`HAAR_VAL_W-1:0] val;
	} db_word_u;

	typedef enum logic [1:0] {
		SLOT_NONE,
		SLOT_HEADER,
		SLOT_STAGE_THR,
		SLOT_FEATURE
	} slot_kind_e;

	// Tag of the word now on the ROM data bus
	typedef struct packed {
		slot_kind_e kind;
		logic [4:0] field;
	} db_slot_t;

	// Corners hold integral values in A, B, C, D order per rectangle
	typedef struct packed {
		logic [11:0][`HAAR_VAL_W-1:0] corner;
		logic [2:0][`HAAR_VAL_W-1:0]  weight;
		logic signed [`HAAR_VAL_W-1:0] thr;
		logic signed [`HAAR_VAL_W-1:0] left;
		logic signed [`HAAR_VAL_W-1:0] right;
	} haar_feature_t;

endpackage

`default_nettype wire

// ==== logic/window_store.sv ====
`default_nettype none

`include "haar_consts.svh"

module window_store
(
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   busy,
	input  wire                   img_we,
	input  wire [`HAAR_IDX_W-1:0] img_addr,
	input  wire [`HAAR_VAL_W-1:0] img_data,
	input  wire [`HAAR_IDX_W-1:0] rd_addr,
	output logic [`HAAR_VAL_W-1:0] rd_data
);

	localparam int SIZE = `HAAR_WIN_W * `HAAR_WIN_H;

	logic [`HAAR_VAL_W-1:0] mem [SIZE];
	logic                   wr_ok;

	// Window is frozen while a cascade runs
	assign wr_ok = img_we && !busy && (img_addr < `HAAR_IDX_W'(`HAAR_WIN_SIZE));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < SIZE; i++)
				mem[i] <= '0;
		end
		else if (wr_ok)
			mem[img_addr] <= img_data;
	end

	// Indices past the window read as zero
	always_comb
	begin
		if (rd_addr < `HAAR_IDX_W'(`HAAR_WIN_SIZE))
			rd_data = mem[rd_addr];
		else
			rd_data = '0;
	end

endmodule

`default_nettype wire

// ==== logic/feature_loader.sv ====
`default_nettype none

`include "haar_consts.svh"

module feature_loader
	import haar_pkg::*;
(
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire db_slot_t         slot,
	input  wire db_word_u         db_data,
	output logic [`HAAR_IDX_W-1:0] rd_addr,
	input  wire [`HAAR_VAL_W-1:0] rd_data,
	output logic                  feat_ready,
	output haar_feature_t         feature
);

	localparam logic [4:0] FLD_THR = 5'(`HAAR_FEAT_WORDS - 3);
	localparam logic [4:0] FLD_LEFT = 5'(`HAAR_FEAT_WORDS - 2);
	localparam logic [4:0] FLD_RIGHT = 5'(`HAAR_FEAT_WORDS - 1);

	haar_feature_t feat_q;
	logic          is_feat;
	logic          is_corner;
	logic          is_weight;
	logic [3:0]    corner_sel;
	logic [1:0]    weight_sel;

	assign is_feat = (slot.kind == SLOT_FEATURE);

	// Corner words carry a window index
	assign rd_addr = db_data.val[`HAAR_IDX_W-1:0];

	// Four corners and then the weight for each rectangle
	always_comb
	begin
		is_corner = 1'b0;
		is_weight = 1'b0;
		corner_sel = '0;
		weight_sel = '0;
		case (slot.field) inside
			[5'd0:5'd3]:
			begin
				is_corner = 1'b1;
				corner_sel = slot.field[3:0];
			end
			[5'd5:5'd8]:
			begin
				is_corner = 1'b1;
				corner_sel = slot.field[3:0] - 4'd1;
			end
			[5'd10:5'd13]:
			begin
				is_corner = 1'b1;
				corner_sel = slot.field[3:0] - 4'd2;
			end
			5'd4:  is_weight = 1'b1;
			5'd9:
			begin
				is_weight = 1'b1;
				weight_sel = 2'd1;
			end
			5'd14:
			begin
				is_weight = 1'b1;
				weight_sel = 2'd2;
			end
			default: is_corner = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			feat_q <= '0;
		else if (is_feat)
		begin
			if (is_corner)
				feat_q.corner[corner_sel] <= rd_data;
			if (is_weight)
				feat_q.weight[weight_sel] <= db_data.val;
			if (slot.field == FLD_THR)
				feat_q.thr <= db_data.val;
			if (slot.field == FLD_LEFT)
				feat_q.left <= db_data.val;
		end
	end

	assign feat_ready = is_feat && (slot.field == FLD_RIGHT);

	// Right leaf comes straight off the bus
	always_comb
	begin
		feature = feat_q;
		feature.right = db_data.val;
	end

endmodule

`default_nettype wire

// ==== logic/haar_feature_eval.sv ====
`default_nettype none

`include "haar_consts.svh"

module haar_feature_eval
	import haar_pkg::*;
(
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           feat_ready,
	input  wire haar_feature_t            feature,
	output logic                          vote_valid,
	output logic signed [`HAAR_VAL_W-1:0] vote
);

	localparam int ACC_W = `HAAR_ACC_W;

	logic signed [ACC_W-1:0] rect_sum [3];
	logic signed [ACC_W-1:0] prod [3];
	logic signed [ACC_W-1:0] value;
	logic signed [ACC_W-1:0] node_thr;

	always_comb
	begin
		value = '0;
		for (int i = 0; i < 3; i++)
		begin
			// A + D - B - C over unsigned integrals
			rect_sum[i] = ACC_W'(feature.corner[4*i])
				+ ACC_W'(feature.corner[4*i+3])
				- ACC_W'(feature.corner[4*i+1])
				- ACC_W'(feature.corner[4*i+2]);
			prod[i] = rect_sum[i] * ACC_W'($signed(feature.weight[i]));
			value = value + prod[i];
		end
	end

	assign node_thr = ACC_W'(feature.thr);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			vote_valid <= 1'b0;
		else
			vote_valid <= feat_ready;
	end

	// Leaf select
	always_ff @(posedge clk)
	begin
		if (feat_ready)
		begin
			if (value > node_thr)
				vote <= feature.right;
			else
				vote <= feature.left;
		end
	end

endmodule

`default_nettype wire

// ==== logic/stage_accum.sv ====
`default_nettype none

`include "haar_consts.svh"

module stage_accum
	import haar_pkg::*;
(
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire db_slot_t                slot,
	input  wire db_word_u                db_data,
	input  wire                          vote_valid,
	input  wire signed [`HAAR_VAL_W-1:0] vote,
	output logic                         stage_pass
);

	logic signed [`HAAR_ACC_W-1:0] vote_sum;
	logic signed [`HAAR_VAL_W-1:0] stage_thr;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vote_sum <= '0;
			stage_thr <= '0;
		end
		else
		begin
			// New stage starts from zero
			if (slot.kind == SLOT_HEADER)
				vote_sum <= '0;
			else if (vote_valid)
				vote_sum <= vote_sum + `HAAR_ACC_W'(vote);
			if (slot.kind == SLOT_STAGE_THR)
				stage_thr <= db_data.val;
		end
	end

	// Sampled by the sequencer on stage_end
	assign stage_pass = (vote_sum > `HAAR_ACC_W'(stage_thr));

endmodule

`default_nettype wire

// ==== logic/cascade_sequencer.sv ====
`default_nettype none

`include "haar_consts.svh"

module cascade_sequencer
	import haar_pkg::*;
(
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    start,
	input  wire db_word_u          db_data,
	input  wire                    stage_pass,
	output logic [`HAAR_DB_AW-1:0] db_addr,
	output db_slot_t               slot,
	output logic                   stage_end,
	output logic                   busy,
	output logic                   done,
	output logic                   candidate,
	output logic [7:0]             stages_run
);

	typedef enum logic [2:0] {
		IDLE,
		HEADER,
		THRESH,
		FEATURES,
		WAIT_VOTE,
		DECIDE
	} state_e;

	state_e     state;
	db_slot_t   tag;
	logic [4:0] field_cnt;
	logic [7:0] feat_left;
	logic       last_stage;
	logic       wait_cnt;

	// Tag for the address issued this cycle
	always_comb
	begin
		tag.kind = SLOT_NONE;
		tag.field = '0;
		case (state)
			HEADER:   tag.kind = SLOT_HEADER;
			THRESH:   tag.kind = SLOT_STAGE_THR;
			FEATURES:
			begin
				tag.kind = SLOT_FEATURE;
				tag.field = field_cnt;
			end
			default:  tag.kind = SLOT_NONE;
		endcase
	end

	assign stage_end = (state == DECIDE);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			db_addr <= '0;
			slot <= '{kind: SLOT_NONE, field: '0};
			field_cnt <= '0;
			feat_left <= '0;
			last_stage <= 1'b0;
			wait_cnt <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			candidate <= 1'b0;
			stages_run <= '0;
		end
		else
		begin
			// Slot trails the address by the ROM latency
			slot <= tag;
			done <= 1'b0;
			case (state)
				IDLE:
				begin
					if (done)
						busy <= 1'b0;
					else if (start)
					begin
						busy <= 1'b1;
						db_addr <= '0;
						stages_run <= '0;
						candidate <= 1'b0;
						state <= HEADER;
					end
				end
				HEADER:
				begin
					db_addr <= db_addr + 1'b1;
					state <= THRESH;
				end
				THRESH:
				begin
					// Header word is on the bus now
					db_addr <= db_addr + 1'b1;
					last_stage <= db_data.hdr.last;
					feat_left <= db_data.hdr.feat_count;
					field_cnt <= '0;
					wait_cnt <= 1'b0;
					if (db_data.hdr.feat_count == 8'd0)
						state <= WAIT_VOTE;
					else
						state <= FEATURES;
				end
				FEATURES:
				begin
					db_addr <= db_addr + 1'b1;
					if (field_cnt == 5'(`HAAR_FEAT_WORDS - 1))
					begin
						field_cnt <= '0;
						if (feat_left == 8'd1)
							state <= WAIT_VOTE;
						else
							feat_left <= feat_left - 8'd1;
					end
					else
						field_cnt <= field_cnt + 5'd1;
				end
				WAIT_VOTE:
				begin
					// Loader and evaluator need two cycles for the last vote
					if (wait_cnt)
						state <= DECIDE;
					else
						wait_cnt <= 1'b1;
				end
				DECIDE:
				begin
					stages_run <= stages_run + 8'd1;
					if (!stage_pass || last_stage)
					begin
						candidate <= stage_pass;
						done <= 1'b1;
						state <= IDLE;
					end
					else
						state <= HEADER;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/haar_cascade.sv ====
`default_nettype none

`include "haar_consts.svh"

module haar_cascade
	import haar_pkg::*;
(
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    img_we,
	input  wire [`HAAR_IDX_W-1:0]  img_addr,
	input  wire [`HAAR_VAL_W-1:0]  img_data,
	input  wire                    start,
	input  wire db_word_u          db_data,
	output logic [`HAAR_DB_AW-1:0] db_addr,
	output logic                   busy,
	output logic                   done,
	output logic                   candidate,
	output logic [7:0]             stages_run
);

	db_slot_t                slot;
	logic                    stage_end;
	logic                    stage_pass;
	logic [`HAAR_IDX_W-1:0]  rd_addr;
	logic [`HAAR_VAL_W-1:0]  rd_data;
	logic                    feat_ready;
	haar_feature_t           feature;
	logic                    vote_valid;
	logic signed [`HAAR_VAL_W-1:0] vote;

	cascade_sequencer u_seq (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.db_data    (db_data),
		.stage_pass (stage_pass),
		.db_addr    (db_addr),
		.slot       (slot),
		.stage_end  (stage_end),
		.busy       (busy),
		.done       (done),
		.candidate  (candidate),
		.stages_run (stages_run)
	);

	window_store u_win (
		.clk      (clk),
		.rst_n    (rst_n),
		.busy     (busy),
		.img_we   (img_we),
		.img_addr (img_addr),
		.img_data (img_data),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

	feature_loader u_load (
		.clk        (clk),
		.rst_n      (rst_n),
		.slot       (slot),
		.db_data    (db_data),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.feat_ready (feat_ready),
		.feature    (feature)
	);

	haar_feature_eval u_eval (
		.clk        (clk),
		.rst_n      (rst_n),
		.feat_ready (feat_ready),
		.feature    (feature),
		.vote_valid (vote_valid),
		.vote       (vote)
	);

	stage_accum u_acc (
		.clk        (clk),
		.rst_n      (rst_n),
		.slot       (slot),
		.db_data    (db_data),
		.vote_valid (vote_valid),
		.vote       (vote),
		.stage_pass (stage_pass)
	);

endmodule

`default_nettype wire

// ==== dv/haar_cascade_props.sv ====
`default_nettype none

`include "haar_consts.svh"

module haar_cascade_props
	import haar_pkg::*;
(
	input wire                   clk,
	input wire                   rst_n,
	input wire                   busy,
	input wire                   done,
	input wire                   candidate,
	input wire [7:0]             stages_run,
	input wire [`HAAR_DB_AW-1:0] db_addr,
	input wire db_slot_t         slot
);
	timeunit 1ns;
	timeprecision 1ps;

	// Read by the testbench at the end of the run
	int err_count = 0;

	reset_quiet: assert property (@(posedge clk)
		(!rst_n || $rose(rst_n)) |-> !busy && !done && !candidate && stages_run == 8'd0)
	else
	begin
		err_count++;
		$error("busy, done or candidate active around reset");
	end

	done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> busy ##1 (!done && !busy))
	else
	begin
		err_count++;
		$error("done is not a single cycle pulse that ends with busy");
	end

	busy_end: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> $past(done))
	else
	begin
		err_count++;
		$error("busy fell without a done pulse");
	end

	// Every tagged word was fetched one address after the previous one
	addr_step: assert property (@(posedge clk) disable iff (!rst_n)
		(slot.kind != SLOT_NONE) |-> db_addr == $past(db_addr) + `HAAR_DB_AW'(1))
	else
	begin
		err_count++;
		$error("ROM address did not advance by one inside a stage");
	end

	result_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> $stable(candidate) && $stable(stages_run))
	else
	begin
		err_count++;
		$error("result changed while the cascade was idle");
	end

endmodule

bind haar_cascade haar_cascade_props u_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.busy       (busy),
	.done       (done),
	.candidate  (candidate),
	.stages_run (stages_run),
	.db_addr    (db_addr),
	.slot       (slot)
);

`default_nettype wire

// ==== dv/haar_cascade_tb.sv ====
`default_nettype none

`include "haar_consts.svh"

module haar_cascade_tb
	import haar_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RUN_LIMIT = 2000;

	logic                   clk;
	logic                   rst_n;
	logic                   img_we;
	logic [`HAAR_IDX_W-1:0] img_addr;
	logic [`HAAR_VAL_W-1:0] img_data;
	logic                   start;
	db_word_u               db_data;
	logic [`HAAR_DB_AW-1:0] db_addr;
	logic                   busy;
	logic                   done;
	logic                   candidate;
	logic [7:0]             stages_run;

	// Reference integral window and cascade database
	logic [`HAAR_VAL_W-1:0] win [`HAAR_WIN_SIZE];
	logic [`HAAR_VAL_W-1:0] rom [1 << `HAAR_DB_AW];
	int                     seed = 32'h9184;
	int                     wr_ptr;
	int                     max_addr;
	int                     stage3_base;

	haar_cascade i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.img_we     (img_we),
		.img_addr   (img_addr),
		.img_data   (img_data),
		.start      (start),
		.db_data    (db_data),
		.db_addr    (db_addr),
		.busy       (busy),
		.done       (done),
		.candidate  (candidate),
		.stages_run (stages_run)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ROM answers one cycle after the address
	always @(posedge clk)
		db_data <= rom[db_addr];

	task automatic abort_with(input string line);
		$display("%s", line);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic int word_signed(input int addr);
		return int'($signed(rom[addr]));
	endfunction

	function automatic int corner_val(input int addr);
		return int'(win[rom[addr][`HAAR_IDX_W-1:0]]);
	endfunction

	// Weighted rectangle as A + D - B - C
	function automatic int rect_term(input int a);
		int area;
		area = corner_val(a) + corner_val(a + 3) - corner_val(a + 1) - corner_val(a + 2);
		return area * word_signed(a + 4);
	endfunction

	function automatic int feature_vote(input int a);
		int value;
		value = rect_term(a) + rect_term(a + 5) + rect_term(a + 10);
		if (value > word_signed(a + 15))
			return word_signed(a + 17);
		else
			return word_signed(a + 16);
	endfunction

	function automatic int stage_sum(input int base);
		int sum;
		int k;
		sum = 0;
		for (k = 0; k < int'(rom[base][7:0]); k++)
			sum += feature_vote(base + 2 + k * `HAAR_FEAT_WORDS);
		return sum;
	endfunction

	// Walk the stages until one fails or the last one passes
	task automatic predict(output bit cand, output int nrun);
		int  base;
		bit  pass;
		bit  last;
		base = 0;
		nrun = 0;
		do
		begin
			last = rom[base][15];
			pass = (stage_sum(base) > word_signed(base + 1));
			nrun++;
			base += 2 + int'(rom[base][7:0]) * `HAAR_FEAT_WORDS;
		end
		while (pass && !last && nrun < 255);
		cand = pass;
	endtask

	task automatic clear_rom();
		int i;
		for (i = 0; i < (1 << `HAAR_DB_AW); i++)
			rom[i] = '0;
		wr_ptr = 0;
	endtask

	task automatic put_word(input int w);
		rom[wr_ptr] = 16'(w);
		wr_ptr++;
	endtask

	task automatic add_stage(input bit last, input int nfeat, input int thr);
		put_word({last, 7'd0, 8'(nfeat)});
		put_word(thr);
	endtask

	task automatic add_rect(input int x0, input int y0, input int x1, input int y1,
		input int w);
		put_word(y0 * `HAAR_WIN_W + x0);
		put_word(y0 * `HAAR_WIN_W + x1);
		put_word(y1 * `HAAR_WIN_W + x0);
		put_word(y1 * `HAAR_WIN_W + x1);
		put_word(w);
	endtask

	task automatic add_random_feature();
		int x0;
		int y0;
		int x1;
		int y1;
		int k;
		for (k = 0; k < 3; k++)
		begin
			x0 = rand_range(0, 8);
			y0 = rand_range(0, 8);
			x1 = rand_range(x0 + 1, 9);
			y1 = rand_range(y0 + 1, 9);
			add_rect(x0, y0, x1, y1, rand_range(-2, 2));
		end
		put_word(rand_range(-200, 200));
		put_word(rand_range(-8, 8));
		put_word(rand_range(-8, 8));
	endtask

	// Thresholds sit just under the window's vote sum, or on it for the failing stage
	task automatic build_three_stage(input int fail_stage);
		int base [3];
		int nfeat [3];
		int s;
		int k;
		nfeat = '{2, 3, 1};
		clear_rom();
		for (s = 0; s < 3; s++)
		begin
			base[s] = wr_ptr;
			add_stage(s == 2, nfeat[s], 0);
			for (k = 0; k < nfeat[s]; k++)
				add_random_feature();
		end
		stage3_base = base[2];
		for (s = 0; s < 3; s++)
			rom[base[s] + 1] = 16'(stage_sum(base[s]) - ((s == fail_stage) ? 0 : 1));
	endtask

	task automatic load_window();
		int i;
		int x;
		int y;
		int acc;
		for (y = 0; y < `HAAR_WIN_H; y++)
			for (x = 0; x < `HAAR_WIN_W; x++)
			begin
				i = y * `HAAR_WIN_W + x;
				acc = rand_range(0, 63);
				if (x > 0)
					acc += int'(win[i - 1]);
				if (y > 0)
					acc += int'(win[i - `HAAR_WIN_W]);
				if (x > 0 && y > 0)
					acc -= int'(win[i - `HAAR_WIN_W - 1]);
				win[i] = 16'(acc);
			end
		for (i = 0; i < `HAAR_WIN_SIZE; i++)
		begin
			@(posedge clk);
			img_we <= 1'b1;
			img_addr <= 7'(i);
			img_data <= win[i];
		end
		@(posedge clk);
		img_we <= 1'b0;
	endtask

	// Optional stray start and window writes during the run
	task automatic run_cascade(input bit disturb);
		int n;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		n = 0;
		max_addr = 0;
		@(negedge clk);
		while (!done)
		begin
			if (n >= RUN_LIMIT)
				abort_with($sformatf("Timeout: done never came within %0d cycles", RUN_LIMIT));
			@(posedge clk);
			start <= disturb && (n == 6);
			img_we <= disturb && (n >= 6);
			img_addr <= 7'(n % `HAAR_WIN_SIZE);
			img_data <= 16'(rand_range(0, 65535));
			@(negedge clk);
			if (busy && int'(db_addr) > max_addr)
				max_addr = int'(db_addr);
			n++;
		end
	endtask

	task automatic check_result(input string name);
		bit exp_cand;
		int exp_run;
		predict(exp_cand, exp_run);
		assert (candidate == exp_cand)
		else
			abort_with($sformatf("Fail at %0d ns: %s candidate is %0b, expected %0b",
				$time, name, candidate, exp_cand));
		assert (stages_run == 8'(exp_run))
		else
			abort_with($sformatf("Fail at %0d ns: %s stages_run is %0d, expected %0d",
				$time, name, stages_run, exp_run));
	endtask

	initial
	begin
		rst_n = 1'b0;
		start = 1'b0;
		img_we = 1'b0;
		img_addr = '0;
		img_data = '0;
		db_data = '0;
		clear_rom();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// One stump comparing two equal boxes side by side
		add_stage(1'b1, 1, 0);
		add_rect(0, 0, 3, 3, 1);
		add_rect(3, 0, 6, 3, -1);
		add_rect(0, 3, 9, 9, 0);
		put_word(0);
		put_word(-3);
		put_word(7);
		repeat (10)
		begin
			load_window();
			run_cascade(1'b0);
			check_result("single feature");
		end

		load_window();
		build_three_stage(-1);
		run_cascade(1'b0);
		check_result("three stage pass");
		assert (candidate && stages_run == 8'd3)
		else
			abort_with($sformatf("Fail at %0d ns: three stage pass gave %0b after %0d stages",
				$time, candidate, stages_run));

		// Same window again with a stray start and blocked writes
		run_cascade(1'b1);
		check_result("frozen window");

		load_window();
		build_three_stage(1);
		run_cascade(1'b0);
		check_result("early reject");
		assert (!candidate && stages_run == 8'd2)
		else
			abort_with($sformatf("Fail at %0d ns: early reject gave %0b after %0d stages",
				$time, candidate, stages_run));
		assert (max_addr <= stage3_base)
		else
			abort_with($sformatf("Fail at %0d ns: ROM address %0d went past stage 3 header %0d",
				$time, max_addr, stage3_base));

		repeat (3) @(posedge clk);
		if (i_dut.u_props.err_count == 0)
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
		else
		begin
			$display("Simulation finished: FAIL");
			$fatal(1, "Protocol assertions failed");
		end
	end

endmodule

`default_nettype wire

// ==== haar_cascade.f ====
+incdir+logic
logic/haar_pkg.sv
logic/window_store.sv
logic/feature_loader.sv
logic/haar_feature_eval.sv
logic/stage_accum.sv
logic/cascade_sequencer.sv
logic/haar_cascade.sv
dv/haar_cascade_props.sv
dv/haar_cascade_tb.sv
